/* flist.f */
rtl/uart_pkg.sv
rtl/byte_fifo.sv
rtl/uart_tx.sv
rtl/tx_path.sv
rtl/uart_rx.sv
rtl/uart_wb_regs.sv
rtl/uart_top.sv
verif/tb_uart.sv

/* rtl/byte_fifo.sv */
// Circular byte buffer with ready/valid ports and a registered read port.
// FIFO_DEPTH must be a power of two; data shows on rd_valid_o two clocks after a push.
`timescale 1ns/1ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 wr_valid_i,
    input  uart_pkg::uart_byte_t wr_data_i,
    output logic                 wr_ready_o,
    output logic                 rd_valid_o,
    output uart_pkg::uart_byte_t rd_data_o,
    input  logic                 rd_ready_i,
    output logic                 empty_o
);
    import uart_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    uart_byte_t       mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full_q;
    logic             empty_q;
    logic             rd_valid_q;
    logic             push;
    logic             pop;

    assign wr_ready_o = !full_q;
    assign rd_valid_o = rd_valid_q;
    assign empty_o    = empty_q;
    assign push       = wr_valid_i && !full_q;
    assign pop        = rd_valid_q && rd_ready_i;

    // storage and registered read, pointers wrap on their own
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_ptr_q];
        if (push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            full_q     <= 1'b0;
            empty_q    <= 1'b1;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= !empty_q && !pop;     // one bubble after each pop
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count_q <= count_q + 1'b1;
                    empty_q <= 1'b0;
                    full_q  <= (count_q == CNT_W'(FIFO_DEPTH - 1));
                end
                2'b01: begin
                    count_q <= count_q - 1'b1;
                    full_q  <= 1'b0;
                    empty_q <= (count_q == CNT_W'(1));
                end
                default: ;                      // both or neither
            endcase
        end
    end

    a_count_max: assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= CNT_W'(FIFO_DEPTH));

endmodule

/* rtl/tx_path.sv */
// Transmit path: byte FIFO feeding the serializer, plus the transmit status levels.
`timescale 1ns/1ps

module tx_path #(
    parameter int CLKS_PER_BIT = 868,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 tx_valid_i,
    input  uart_pkg::uart_byte_t tx_data_i,
    output logic                 tx_ready_o,
    output logic                 tx_full_o,
    output logic                 tx_empty_o,
    output logic                 tx_busy_o,
    output logic                 txd_o
);
    import uart_pkg::*;

    logic       fifo_valid;
    uart_byte_t fifo_data;
    logic       ser_ready;

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wr_valid_i (tx_valid_i),
        .wr_data_i  (tx_data_i),
        .wr_ready_o (tx_ready_o),
        .rd_valid_o (fifo_valid),
        .rd_data_o  (fifo_data),
        .rd_ready_i (ser_ready),
        .empty_o    (tx_empty_o)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (fifo_valid),
        .data_i  (fifo_data),
        .ready_o (ser_ready),
        .txd_o   (txd_o)
    );

    assign tx_full_o = !tx_ready_o;     // no slot left
    assign tx_busy_o = !ser_ready;      // frame on the wire

endmodule

/* rtl/uart_pkg.sv */
// Shared types and register map of the Wishbone serial port.
// Modules import this package inside their body and use scoped names in port lists.
package uart_pkg;

    // ------------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------------
    localparam int REG_ADDR_W = 2;          // word offsets on the bus

    localparam logic [REG_ADDR_W-1:0] REG_TX_DATA = REG_ADDR_W'(0);  // write only
    localparam logic [REG_ADDR_W-1:0] REG_RX_DATA = REG_ADDR_W'(1);  // read pops
    localparam logic [REG_ADDR_W-1:0] REG_STATUS  = REG_ADDR_W'(2);  // read only

    // one serial data byte
    typedef logic [7:0] uart_byte_t;

    // ------------------------------------------------------------------------
    // Wishbone classic, byte wide
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [REG_ADDR_W-1:0] adr;
        uart_byte_t            dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        uart_byte_t dat;            // read data, valid with ack
    } wb_rsp_t;

    // status word as seen at REG_STATUS
    typedef struct packed {
        logic [3:0] rsvd;           // reads zero
        logic       tx_busy;
        logic       tx_empty;
        logic       tx_full;
        logic       rx_valid;       // bit 0
    } uart_status_t;

endpackage

/* rtl/uart_rx.sv */
// Deserializer: input synchronizer, start detection by low count, mid-bit sampling.
// The received byte is held with valid_o until ready_i; a newer byte overwrites it.
`timescale 1ns/1ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868,
    parameter int DETECT_COUNT = 4
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 rxd_i,
    output logic                 valid_o,
    output uart_pkg::uart_byte_t data_o,
    input  logic                 ready_i
);
    import uart_pkg::*;

    localparam logic IDLE = 1'b0;
    localparam logic RUN  = 1'b1;

    // clocks from start confirmation to the middle of data bit 0,
    // covering the synchronizer delay and the low samples already taken
    localparam int FIRST_WAIT = CLKS_PER_BIT + CLKS_PER_BIT / 2 + 1 - DETECT_COUNT;
    localparam int WAIT_MAX   = (FIRST_WAIT > CLKS_PER_BIT) ? FIRST_WAIT : CLKS_PER_BIT;
    localparam int WAIT_W     = $clog2(WAIT_MAX);
    localparam int DET_W      = $clog2(DETECT_COUNT + 1);

    logic              rxd_meta_q;
    logic              rxd_sync_q;
    logic              state_q;
    logic [DET_W-1:0]  detect_cnt_q;
    logic [3:0]        bit_cnt_q;       // 8..1 data bits, 0 stop bit
    logic [WAIT_W-1:0] wait_cnt_q;
    logic              sample;
    logic              frame_done;
    logic              valid_q;
    uart_byte_t        shift_q;
    uart_byte_t        data_q;

    assign sample     = (state_q == RUN) && (wait_cnt_q == '0);
    assign frame_done = sample && (bit_cnt_q == '0);    // middle of stop bit
    assign valid_o    = valid_q;
    assign data_o     = data_q;

    // ------------------------------------------------------------------------
    // two-flop synchronizer
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rxd_meta_q <= 1'b1;
            rxd_sync_q <= 1'b1;
        end else begin
            rxd_meta_q <= rxd_i;
            rxd_sync_q <= rxd_meta_q;
        end
    end

    // ------------------------------------------------------------------------
    // frame FSM and output hold
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q      <= IDLE;
            detect_cnt_q <= '0;
            bit_cnt_q    <= '0;
            wait_cnt_q   <= '0;
            valid_q      <= 1'b0;
        end else begin
            if (frame_done) begin
                valid_q <= 1'b1;                // overrun replaces the old byte
            end else if (valid_q && ready_i) begin
                valid_q <= 1'b0;
            end
            case (state_q)
                IDLE: begin
                    if (rxd_sync_q) begin
                        detect_cnt_q <= '0;     // glitch, start over
                    end else if (detect_cnt_q == DET_W'(DETECT_COUNT - 1)) begin
                        detect_cnt_q <= '0;
                        bit_cnt_q    <= 4'd8;
                        wait_cnt_q   <= WAIT_W'(FIRST_WAIT - 1);
                        state_q      <= RUN;
                    end else begin
                        detect_cnt_q <= detect_cnt_q + 1'b1;
                    end
                end
                default: begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                    if (sample) begin
                        wait_cnt_q <= WAIT_W'(CLKS_PER_BIT - 1);
                        bit_cnt_q  <= bit_cnt_q - 1'b1;
                        if (bit_cnt_q == '0) begin
                            state_q <= IDLE;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample && bit_cnt_q != '0) begin
            shift_q <= {rxd_sync_q, shift_q[7:1]};     // LSB arrives first
        end
        if (frame_done) begin
            data_q <= shift_q;
        end
    end

    // stop bit reads high at its middle when the sampling point is aligned
    a_stop_high: assert property (@(posedge clk_i) disable iff (rst_i)
        frame_done |-> rxd_sync_q);

endmodule

/* rtl/uart_top.sv */
// Serial port peripheral on a Wishbone classic slave bus.
// Set CLKS_PER_BIT to clock rate over baud rate; FIFO_DEPTH must be a power of two.
`timescale 1ns/1ps

module uart_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int DETECT_COUNT = 4,
    parameter int FIFO_DEPTH   = 16
) (
    input  logic              clk_i,
    input  logic              rst_i,
    input  uart_pkg::wb_req_t wb_req_i,
    output uart_pkg::wb_rsp_t wb_rsp_o,
    input  logic              rxd_i,
    output logic              txd_o
);
    import uart_pkg::*;

    logic       tx_valid;
    uart_byte_t tx_data;
    logic       tx_ready;
    logic       tx_full;
    logic       tx_empty;
    logic       tx_busy;
    logic       rx_valid;
    uart_byte_t rx_data;
    logic       rx_ready;

    uart_wb_regs u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .tx_valid_o (tx_valid),
        .tx_data_o  (tx_data),
        .tx_ready_i (tx_ready),
        .tx_full_i  (tx_full),
        .tx_empty_i (tx_empty),
        .tx_busy_i  (tx_busy),
        .rx_valid_i (rx_valid),
        .rx_data_i  (rx_data),
        .rx_ready_o (rx_ready)
    );

    tx_path #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) u_tx_path (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .tx_valid_i (tx_valid),
        .tx_data_i  (tx_data),
        .tx_ready_o (tx_ready),
        .tx_full_o  (tx_full),
        .tx_empty_o (tx_empty),
        .tx_busy_o  (tx_busy),
        .txd_o      (txd_o)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .DETECT_COUNT (DETECT_COUNT)
    ) u_rx (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .rxd_i   (rxd_i),
        .valid_o (rx_valid),
        .data_o  (rx_data),
        .ready_i (rx_ready)
    );

endmodule

/* rtl/uart_tx.sv */
// Serializer: start bit, eight data bits LSB first, stop bit; CLKS_PER_BIT clocks each.
`timescale 1ns/1ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 valid_i,
    input  uart_pkg::uart_byte_t data_i,
    output logic                 ready_o,
    output logic                 txd_o
);
    localparam logic IDLE   = 1'b0;
    localparam logic RUN    = 1'b1;
    localparam int   WAIT_W = $clog2(CLKS_PER_BIT);

    logic              state_q;
    logic [8:0]        shift_q;         // {data, start}, ones shift in behind
    logic [3:0]        bit_cnt_q;
    logic [WAIT_W-1:0] wait_cnt_q;

    assign txd_o   = shift_q[0];
    assign ready_o = (state_q == IDLE);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= IDLE;
            shift_q    <= '1;           // line idles high
            bit_cnt_q  <= '0;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (valid_i) begin
                        shift_q    <= {data_i, 1'b0};
                        bit_cnt_q  <= 4'd9;
                        wait_cnt_q <= WAIT_W'(CLKS_PER_BIT - 1);
                        state_q    <= RUN;
                    end
                end
                default: begin
                    wait_cnt_q <= wait_cnt_q - 1'b1;
                    if (wait_cnt_q == '0) begin
                        shift_q    <= {1'b1, shift_q[8:1]};
                        bit_cnt_q  <= bit_cnt_q - 1'b1;
                        wait_cnt_q <= WAIT_W'(CLKS_PER_BIT - 1);
                    end
                    // ready in the last clock of the stop bit, so frames abut
                    if (bit_cnt_q == '0 && wait_cnt_q == WAIT_W'(1)) begin
                        state_q <= IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* rtl/uart_wb_regs.sv */
// Wishbone register block: transmit writes, receive pops and the merged status word.
`timescale 1ns/1ps

module uart_wb_regs (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  uart_pkg::wb_req_t    wb_req_i,
    output uart_pkg::wb_rsp_t    wb_rsp_o,
    output logic                 tx_valid_o,
    output uart_pkg::uart_byte_t tx_data_o,
    input  logic                 tx_ready_i,
    input  logic                 tx_full_i,
    input  logic                 tx_empty_i,
    input  logic                 tx_busy_i,
    input  logic                 rx_valid_i,
    input  uart_pkg::uart_byte_t rx_data_i,
    output logic                 rx_ready_o
);
    import uart_pkg::*;

    logic         req;
    logic         wr_tx;
    logic         done;
    logic         ack_q;
    uart_byte_t   rdat_d;
    uart_byte_t   rdat_q;
    uart_status_t status;

    // a cycle counts only until it has been acked
    assign req   = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_tx = req && wb_req_i.we && (wb_req_i.adr == REG_TX_DATA);
    assign done  = wr_tx ? tx_ready_i : req;    // tx write waits for a FIFO slot

    assign tx_valid_o = wr_tx;
    assign tx_data_o  = wb_req_i.dat;
    assign rx_ready_o = req && !wb_req_i.we && (wb_req_i.adr == REG_RX_DATA);  // pop on read

    assign status = '{
        rsvd:     '0,
        tx_busy:  tx_busy_i,
        tx_empty: tx_empty_i,
        tx_full:  tx_full_i,
        rx_valid: rx_valid_i
    };

    // read mux, zero for writes and unmapped offsets
    always_comb begin
        rdat_d = '0;
        if (!wb_req_i.we) begin
            case (wb_req_i.adr)
                REG_RX_DATA: rdat_d = rx_valid_i ? rx_data_i : '0;
                REG_STATUS:  rdat_d = status;
                default:     rdat_d = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (done) begin
            rdat_q <= rdat_d;
        end
    end

    assign wb_rsp_o = '{ack: ack_q, dat: rdat_q};

    // the transmit buffer never reports full and empty at once
    a_status_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        !(tx_full_i && tx_empty_i));

endmodule

/* run.sh */
#!/usr/bin/env bash
# build with Verilator and run; exit status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_uart -f flist.f -o sim_uart \
    && ./obj_dir/sim_uart | tee /dev/stderr | grep -q ">>> PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

/* verif/tb_uart.sv */
// Self-checking testbench for the Wishbone serial port, with txd looped back to rxd.
// Bytes come from a table, are sent through the transmit register and read back from the receiver.
`timescale 1ns/1ps

module tb_uart;
    import uart_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int DETECT_COUNT = 4;
    localparam int FIFO_DEPTH   = 4;
    localparam int N_VEC        = 10;
    localparam int ACK_TIMEOUT  = 40 * CLKS_PER_BIT;   // covers a full frame of back-pressure
    localparam int POLL_LIMIT   = 100;

    typedef struct packed {
        uart_byte_t stim;
        uart_byte_t echo;                   // byte expected back over the loop
    } vec_t;

    logic    clk_i;
    logic    rst_i;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    txd;
    vec_t    tbl [N_VEC];
    int      n_chk;
    int      n_err;

    uart_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .DETECT_COUNT (DETECT_COUNT),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) i_dut (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .rxd_i    (txd),                    // loopback
        .txd_o    (txd)
    );

    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        n_chk++;
        assert (got === exp) else begin
            n_err++;
            $display("error %s: got %02h, expected %02h", name, got, exp);
        end
    endtask

    // one classic cycle, starts and ends on a falling edge
    task automatic bus_cycle(input logic we, input logic [REG_ADDR_W-1:0] adr,
                             input uart_byte_t wdat, output uart_byte_t rdat);
        int   waited;
        logic acked;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        while (!acked && waited < ACK_TIMEOUT) begin
            @(negedge clk_i);
            waited++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        wb_req = '0;                        // drop stb after ack
        if (!acked) begin
            n_err++;
            $display("timeout: no ack for access to offset %0d", adr);
        end else begin
            if (!we) begin
                check_val("read ack latency", 8'(waited), 8'h01);
            end
            @(negedge clk_i);
            check_val("ack", {7'b0, wb_rsp.ack}, 8'h00);   // single pulse
        end
    endtask

    task automatic write_reg(input logic [REG_ADDR_W-1:0] adr, input uart_byte_t wdat);
        uart_byte_t unused;
        bus_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic read_reg(input logic [REG_ADDR_W-1:0] adr, output uart_byte_t rdat);
        bus_cycle(1'b0, adr, 8'h00, rdat);
    endtask

    task automatic wait_rx_valid();
        uart_status_t st;
        uart_byte_t   rd;
        int           polls;
        polls = 0;
        st    = '0;
        while (!st.rx_valid && polls < POLL_LIMIT) begin
            read_reg(REG_STATUS, rd);
            st = rd;
            polls++;
        end
        if (!st.rx_valid) begin
            n_err++;
            $display("timeout: no received byte after %0d status polls", polls);
        end
    endtask

    function automatic void fill_table();
        uart_byte_t b;
        int         k;
        for (k = 0; k < N_VEC; k++) begin
            case (k)
                0:       b = 8'h00;
                1:       b = 8'hFF;
                2:       b = 8'h55;
                3:       b = 8'hAA;
                default: b = uart_byte_t'($urandom);
            endcase
            tbl[k] = '{stim: b, echo: b};   // loopback returns the byte unchanged
        end
    endfunction

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        uart_byte_t   rd;
        uart_status_t st;
        uart_status_t exp_st;
        int           i;
        void'($urandom(5));
        clk_i  = 1'b0;
        rst_i  = 1'b1;
        wb_req = '0;
        n_chk  = 0;
        n_err  = 0;
        fill_table();
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);

        // idle state after reset
        exp_st          = '0;
        exp_st.tx_empty = 1'b1;
        read_reg(REG_STATUS, rd);
        check_val("status", rd, exp_st);
        check_val("txd_o", {7'b0, txd}, 8'h01);

        // one byte at a time, then the emptied receiver
        for (i = 0; i < N_VEC; i++) begin
            write_reg(REG_TX_DATA, tbl[i].stim);
            wait_rx_valid();
            read_reg(REG_RX_DATA, rd);
            check_val("rx_data", rd, tbl[i].echo);
            read_reg(REG_STATUS, rd);
            st = rd;
            check_val("rx_valid", {7'b0, st.rx_valid}, 8'h00);
            read_reg(REG_RX_DATA, rd);
            check_val("rx_data after pop", rd, 8'h00);
        end

        // burst past the buffer depth, serializer holds one byte
        for (i = 0; i <= FIFO_DEPTH; i++) begin
            write_reg(REG_TX_DATA, tbl[i].stim);
        end
        exp_st         = '0;
        exp_st.tx_full = 1'b1;
        exp_st.tx_busy = 1'b1;              // first frame still on the wire
        read_reg(REG_STATUS, rd);
        check_val("status", rd, exp_st);
        write_reg(REG_TX_DATA, tbl[FIFO_DEPTH+1].stim);    // stalls until a slot frees
        for (i = 0; i < FIFO_DEPTH + 2; i++) begin
            wait_rx_valid();
            read_reg(REG_RX_DATA, rd);
            check_val("rx_data burst", rd, tbl[i].echo);
        end

        // unmapped offset
        read_reg(2'd3, rd);
        check_val("offset 3", rd, 8'h00);

        $display("checks %0d, errors %0d", n_chk, n_err);
        if (n_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
